/* hdl/uart_link_pkg.sv */
`default_nettype none

package uart_link_pkg;

    typedef logic [7:0]  byte_t;      // one uart data byte
    typedef logic [31:0] word_t;      // transferred word
    typedef logic [1:0]  byte_idx_t;  // byte slot in a word
    typedef logic [3:0]  os_cnt_t;    // oversample ticks in a bit

    localparam int OVERSAMPLE     = 16;
    localparam int BYTES_PER_WORD = 4;

    typedef struct packed {
        word_t data;
        logic  frame_err;  // any stop bit low
    } rx_word_t;

endpackage

`default_nettype wire

/* hdl/baud_tick_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module baud_tick_gen #(
    parameter int CLK_DIV = 27
) (
    input  wire  i_clk,
    input  wire  i_rst_n,
    output logic o_tick
);

    localparam int CNT_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLK_DIV - 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt    <= '0;
            o_tick <= 1'b0;
        end else begin
            if (cnt == CNT_LAST) begin
                cnt    <= '0;
                o_tick <= 1'b1;  // one pulse per reload
            end else begin
                cnt    <= cnt + 1'b1;
                o_tick <= 1'b0;
            end
        end
    end

    // a zero divider would never reload
    a_div_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        CLK_DIV >= 1);

endmodule

`default_nettype wire

/* hdl/uart_tx_byte.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_tx_byte
    import uart_link_pkg::*;
(
    input  wire   i_clk,
    input  wire   i_rst_n,
    input  wire   i_tick,
    input  wire   i_start,
    input  byte_t i_data,
    output logic  o_serial,
    output logic  o_byte_done
);

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } tx_state_t;

    localparam os_cnt_t OS_LAST = os_cnt_t'(OVERSAMPLE - 1);

    tx_state_t  state;
    os_cnt_t    os_cnt;
    logic [2:0] bit_cnt;
    logic       pend;      // strobe seen, waiting for tick
    logic       bit_end;
    byte_t      shreg;

    assign bit_end = i_tick && (os_cnt == OS_LAST);

    always_ff @(posedge i_clk) begin
        if (state == IDLE && i_start) begin
            shreg <= i_data;
        end else if (state == DATA && bit_end) begin
            shreg <= {1'b0, shreg[7:1]};  // lsb first
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state       <= IDLE;
            pend        <= 1'b0;
            os_cnt      <= '0;
            bit_cnt     <= '0;
            o_serial    <= 1'b1;
            o_byte_done <= 1'b0;
        end else begin
            o_byte_done <= 1'b0;
            if (state != IDLE && i_tick && !bit_end) begin
                os_cnt <= os_cnt + 1'b1;
            end
            case (state)
                IDLE: begin
                    if (i_start) begin
                        pend <= 1'b1;
                    end
                    if (pend && i_tick) begin  // align start bit to tick grid
                        pend     <= 1'b0;
                        state    <= START;
                        os_cnt   <= '0;
                        o_serial <= 1'b0;
                    end
                end
                START: begin
                    if (bit_end) begin
                        state    <= DATA;
                        os_cnt   <= '0;
                        bit_cnt  <= '0;
                        o_serial <= shreg[0];
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        os_cnt <= '0;
                        if (bit_cnt == 3'd7) begin
                            state    <= STOP;
                            o_serial <= 1'b1;
                        end else begin
                            bit_cnt  <= bit_cnt + 1'b1;
                            o_serial <= shreg[1];
                        end
                    end
                end
                STOP: begin
                    if (bit_end) begin
                        state       <= IDLE;
                        os_cnt      <= '0;
                        o_byte_done <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_idle_high: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (state == IDLE) |-> o_serial);

endmodule

`default_nettype wire

/* hdl/uart_tx_word.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_tx_word
    import uart_link_pkg::*;
(
    input  wire   i_clk,
    input  wire   i_rst_n,
    input  wire   i_tick,
    input  wire   i_tx_en,
    input  word_t i_tx_word,
    output logic  o_tx_serial,
    output logic  o_tx_busy,
    output logic  o_tx_done
);

    localparam byte_idx_t LAST_IDX = byte_idx_t'(BYTES_PER_WORD - 1);

    word_t     word_q;
    byte_idx_t idx;
    byte_t     cur_byte;
    logic      start_q;
    logic      byte_done;

    assign cur_byte = word_q[{idx, 3'b000} +: 8];

    always_ff @(posedge i_clk) begin
        if (i_tx_en && !o_tx_busy) begin
            word_q <= i_tx_word;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            start_q   <= 1'b0;
            idx       <= '0;
            o_tx_busy <= 1'b0;
            o_tx_done <= 1'b0;
        end else begin
            start_q   <= 1'b0;
            o_tx_done <= 1'b0;
            if (i_tx_en && !o_tx_busy) begin
                o_tx_busy <= 1'b1;
                start_q   <= 1'b1;  // byte 0
                idx       <= '0;
            end else if (byte_done) begin
                if (idx == LAST_IDX) begin
                    o_tx_busy <= 1'b0;
                    o_tx_done <= 1'b1;
                    idx       <= '0;
                end else begin
                    idx     <= idx + 1'b1;
                    start_q <= 1'b1;  // chain next byte
                end
            end
        end
    end

    uart_tx_byte u_tx_byte (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_tick      (i_tick),
        .i_start     (start_q),
        .i_data      (cur_byte),
        .o_serial    (o_tx_serial),
        .o_byte_done (byte_done)
    );

    a_done_in_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_tx_done |-> $past(o_tx_busy));

endmodule

`default_nettype wire

/* hdl/uart_rx_byte.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_rx_byte
    import uart_link_pkg::*;
(
    input  wire   i_clk,
    input  wire   i_rst_n,
    input  wire   i_tick,
    input  wire   i_serial,
    output byte_t o_byte,
    output logic  o_byte_valid,
    output logic  o_stop_err
);

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } rx_state_t;

    localparam os_cnt_t OS_MID  = os_cnt_t'(OVERSAMPLE / 2 - 1);
    localparam os_cnt_t OS_LAST = os_cnt_t'(OVERSAMPLE - 1);

    rx_state_t  state;
    os_cnt_t    os_cnt;
    logic [2:0] bit_cnt;
    logic       rx_meta;
    logic       rx_sync;
    logic       rx_prev;
    logic       bit_mid;
    byte_t      shreg;

    assign bit_mid = i_tick && (os_cnt == OS_LAST);
    assign o_byte  = shreg;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= i_serial;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;  // for edge detect
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == DATA && bit_mid) begin
            shreg <= {rx_sync, shreg[7:1]};
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state        <= IDLE;
            os_cnt       <= '0;
            bit_cnt      <= '0;
            o_byte_valid <= 1'b0;
            o_stop_err   <= 1'b0;
        end else begin
            o_byte_valid <= 1'b0;
            if (state != IDLE && i_tick) begin
                os_cnt <= os_cnt + 1'b1;
            end
            case (state)
                IDLE: begin
                    if (rx_prev && !rx_sync) begin  // falling edge
                        state  <= START;
                        os_cnt <= '0;
                    end
                end
                START: begin
                    if (i_tick && os_cnt == OS_MID) begin
                        os_cnt  <= '0;
                        bit_cnt <= '0;
                        // glitch shorter than half a bit
                        state   <= rx_sync ? IDLE : DATA;
                    end
                end
                DATA: begin
                    if (bit_mid) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= STOP;
                        end
                    end
                end
                STOP: begin
                    if (bit_mid) begin
                        state        <= IDLE;
                        o_byte_valid <= 1'b1;
                        o_stop_err   <= !rx_sync;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_valid_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_byte_valid |=> !o_byte_valid);

endmodule

`default_nettype wire

/* hdl/uart_rx_word.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_rx_word
    import uart_link_pkg::*;
(
    input  wire      i_clk,
    input  wire      i_rst_n,
    input  byte_t    i_byte,
    input  wire      i_byte_valid,
    input  wire      i_stop_err,
    output rx_word_t o_rx_word,
    output logic     o_rx_valid
);

    localparam byte_idx_t LAST_IDX = byte_idx_t'(BYTES_PER_WORD - 1);

    byte_idx_t idx;
    word_t     word_q;
    word_t     word_next;
    logic      err_q;

    always_comb begin
        word_next = word_q;
        word_next[{idx, 3'b000} +: 8] = i_byte;  // byte lands at its slot
    end

    always_ff @(posedge i_clk) begin
        if (i_byte_valid) begin
            word_q <= word_next;
            if (idx == LAST_IDX) begin
                o_rx_word.data      <= word_next;
                o_rx_word.frame_err <= err_q | i_stop_err;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            idx        <= '0;
            err_q      <= 1'b0;
            o_rx_valid <= 1'b0;
        end else begin
            o_rx_valid <= 1'b0;
            if (i_byte_valid) begin
                if (idx == LAST_IDX) begin
                    idx        <= '0;
                    err_q      <= 1'b0;
                    o_rx_valid <= 1'b1;
                end else begin
                    idx   <= idx + 1'b1;
                    err_q <= err_q | i_stop_err;  // sticky per word
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/uart_word_link.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_word_link
    import uart_link_pkg::*;
#(
    parameter int CLK_DIV = 27  // clocks per oversample tick
) (
    input  wire      i_clk,
    input  wire      i_rst_n,
    input  wire      i_tx_en,
    input  word_t    i_tx_word,
    input  wire      i_rx_serial,
    output logic     o_tx_serial,
    output logic     o_tx_busy,
    output logic     o_tx_done,
    output rx_word_t o_rx_word,
    output logic     o_rx_valid
);

    logic  tick;
    byte_t rx_byte;
    logic  rx_byte_valid;
    logic  rx_stop_err;

    baud_tick_gen #(
        .CLK_DIV (CLK_DIV)
    ) u_baud (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .o_tick  (tick)
    );

    uart_tx_word u_tx (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_tick      (tick),
        .i_tx_en     (i_tx_en),
        .i_tx_word   (i_tx_word),
        .o_tx_serial (o_tx_serial),
        .o_tx_busy   (o_tx_busy),
        .o_tx_done   (o_tx_done)
    );

    uart_rx_byte u_rx_byte (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_tick       (tick),
        .i_serial     (i_rx_serial),
        .o_byte       (rx_byte),
        .o_byte_valid (rx_byte_valid),
        .o_stop_err   (rx_stop_err)
    );

    uart_rx_word u_rx_word (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_byte       (rx_byte),
        .i_byte_valid (rx_byte_valid),
        .i_stop_err   (rx_stop_err),
        .o_rx_word    (o_rx_word),
        .o_rx_valid   (o_rx_valid)
    );

endmodule

`default_nettype wire

/* dv/tb_uart_word_link.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_uart_word_link
    import uart_link_pkg::*;
();

    localparam int BIT_CYC = 2 * OVERSAMPLE;  // clocks per bit at CLK_DIV 2
    localparam int LIMIT   = 50 * BIT_CYC;

    logic     i_clk;
    logic     i_rst_n;
    logic     i_tx_en;
    word_t    i_tx_word;
    logic     i_rx_serial = 1'b1;
    logic     o_tx_serial;
    logic     o_tx_busy;
    logic     o_tx_done;
    rx_word_t o_rx_word;
    logic     o_rx_valid;
    logic     use_bang;  // rx line fed by bit-banged frames
    logic     bang_bit;
    int       done_cnt = 0;
    int       rx_cnt = 0;
    rx_word_t rx_last;
    int       mism_cnt = 0;
    int       fail_cnt = 0;

    uart_word_link #(.CLK_DIV(2)) UUT (.*);

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        i_rx_serial <= use_bang ? bang_bit : o_tx_serial;
    end

    always @(negedge i_clk) begin
        if (o_tx_done) done_cnt <= done_cnt + 1;
        if (o_rx_valid) rx_cnt <= rx_cnt + 1;
        if (o_rx_valid) rx_last <= o_rx_word;
    end

    task automatic note_mismatch(input string msg);
        $display("mismatch at %0t: %s", $time, msg);
        mism_cnt++;
    endtask

    task automatic report_timeout(input string what);
        $display("timed out waiting for %s", what);
        fail_cnt++;
    endtask

    // rebuilds a word from the tx line, sampling mid-bit from each start edge
    task automatic decode_line_word(output word_t w);
        int n;
        w = '0;
        for (int i = 0; i < BYTES_PER_WORD; i++) begin
            n = 0;
            while (o_tx_serial === 1'b1 && n < LIMIT) begin
                @(negedge i_clk);
                n++;
            end
            if (n == LIMIT) begin
                report_timeout("a start bit on the tx line");
                return;
            end
            repeat (BIT_CYC / 2) @(negedge i_clk);
            if (o_tx_serial !== 1'b0) begin
                note_mismatch($sformatf("start bit of byte %0d not low", i));
            end
            for (int j = 0; j < 8; j++) begin
                repeat (BIT_CYC) @(negedge i_clk);
                w[8 * i + j] = o_tx_serial;  // lsb first
            end
            repeat (BIT_CYC) @(negedge i_clk);
            if (o_tx_serial !== 1'b1) begin
                note_mismatch($sformatf("stop bit of byte %0d not high", i));
            end
        end
    endtask

    // four frames on the rx line, stop bit of byte k driven low
    task automatic bang_word(input word_t w, input int k);
        logic [10:0] frame;
        @(posedge i_clk);
        use_bang <= 1'b1;
        for (int i = 0; i < BYTES_PER_WORD; i++) begin
            frame = {1'b1, i != k, w[8 * i +: 8], 1'b0};  // idle, stop, data, start
            for (int j = 0; j < 11; j++) begin
                bang_bit <= frame[j];
                repeat (BIT_CYC) @(posedge i_clk);
            end
        end
        use_bang <= 1'b0;
    endtask

    task automatic run_case(input word_t w, exp_w, input int mode, exp_err, k);
        word_t line_w;
        int    done_base;
        int    rx_base;
        int    n;
        done_base = done_cnt;
        rx_base   = rx_cnt;
        if (mode == 2) begin
            bang_word(w, k);
        end else begin
            @(posedge i_clk);
            i_tx_en   <= 1'b1;
            i_tx_word <= w;
            @(posedge i_clk);
            i_tx_en   <= (mode == 1);  // lands while busy is already high
            i_tx_word <= ~w;
            @(posedge i_clk);
            i_tx_en <= 1'b0;
            decode_line_word(line_w);
            if (line_w !== w) begin
                note_mismatch($sformatf("tx line word %h, expected %h", line_w, w));
            end
        end
        n = 0;
        while ((rx_cnt <= rx_base || (mode != 2 && done_cnt <= done_base)) && n < LIMIT) begin
            @(negedge i_clk);
            n++;
        end
        if (n == LIMIT) report_timeout("o_rx_valid and o_tx_done");
        repeat (12 * BIT_CYC) @(negedge i_clk);  // nothing more may follow
        if (rx_last.data !== exp_w) begin
            note_mismatch($sformatf("rx word %h, expected %h", rx_last.data, exp_w));
        end
        if (rx_last.frame_err !== exp_err[0]) begin
            note_mismatch($sformatf("frame_err %b, expected %0d", rx_last.frame_err, exp_err));
        end
        if (rx_cnt != rx_base + 1) begin
            note_mismatch($sformatf("%0d rx valid pulses, expected 1", rx_cnt - rx_base));
        end
        if (done_cnt != done_base + ((mode == 2) ? 0 : 1)) begin
            note_mismatch($sformatf("%0d tx done pulses for mode %0d", done_cnt - done_base, mode));
        end
        if (o_tx_busy !== 1'b0 || o_tx_serial !== 1'b1) note_mismatch("tx not idle after word");
    endtask

    initial begin
        int    fd;
        int    n_case;
        string line;
        word_t w;
        word_t exp_w;
        int    mode;
        int    exp_err;
        int    k;
        void'($urandom(32'h67004eb8));
        n_case    = 0;
        i_rst_n   <= 1'b0;
        i_tx_en   <= 1'b0;
        i_tx_word <= '0;
        use_bang  <= 1'b0;
        bang_bit  <= 1'b1;
        repeat (5) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(negedge i_clk);
        if (o_tx_serial !== 1'b1 || o_tx_busy !== 1'b0 || o_tx_done !== 1'b0
                || o_rx_valid !== 1'b0) begin
            note_mismatch("outputs not at their reset values");
        end
        fd = $fopen("dv/uart_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/uart_testdata.txt");
            fail_cnt++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if ($sscanf(line, "%h %d %h %d %d", w, mode, exp_w, exp_err, k) == 5) begin
                    n_case++;
                    run_case(w, exp_w, mode, exp_err, k);
                    repeat ($urandom_range(40, 4)) @(posedge i_clk);  // idle gap
                end
            end
            $fclose(fd);
        end
        if (n_case == 0) begin
            $display("no cases were read from the testdata file");
            fail_cnt++;
        end
        $display("%0d cases, %0d mismatches, %0d other errors", n_case, mism_cnt, fail_cnt);
        if (mism_cnt == 0 && fail_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/uart_testdata.txt */
# columns: word (hex), mode (0 loopback, 1 busy re-strobe, 2 low stop bit),
# expected rx word (hex), expected frame_err, byte with the low stop bit in mode 2
12345678 0 12345678 0 0
00000000 0 00000000 0 0
ffffffff 0 ffffffff 0 0
a5c30f96 1 a5c30f96 0 0
0badf00d 2 0badf00d 1 0
80000001 0 80000001 0 0
5a5a5a5a 2 5a5a5a5a 1 3
13579bdf 1 13579bdf 0 0
7e7e0102 2 7e7e0102 1 1
fedcba98 0 fedcba98 0 0
01020304 2 01020304 1 2
55aa55aa 0 55aa55aa 0 0

/* build.f */
hdl/uart_link_pkg.sv
hdl/baud_tick_gen.sv
hdl/uart_tx_byte.sv
hdl/uart_tx_word.sv
hdl/uart_rx_byte.sv
hdl/uart_rx_word.sv
hdl/uart_word_link.sv
dv/tb_uart_word_link.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f build.f --top-module tb_uart_word_link -o tb_sim \
    > build.log 2>&1 || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
